//--- dma_arbiter.sv
// round-robin dma arbiter

`timescale 1ns/1ns
`default_nettype none

`include "dma_sec_consts.svh"

module dma_arbiter (
	input  wire logic                   clk,
	input  wire logic                   reset,

	// debug gate
	input  wire logic                   dbg_fwd_val,
	input  wire dma_req_pkg::dbg_req_t  dbg_fwd_payload,
	output logic                        dbg_fwd_done,

	// core gate
	input  wire logic                   core_fwd_val,
	input  wire dma_req_pkg::core_req_t core_fwd_payload,
	output logic                        core_fwd_done,

	// result, shared by both gates
	output logic      [`DMA_DATA_W-1:0] fwd_rdata,

	// engine command
	output logic                        start,
	output dma_req_pkg::op_t            op,
	output logic      [`DMA_ADDR_W-1:0] src,
	output logic      [`DMA_ADDR_W-1:0] dest,
	output logic      [`DMA_DATA_W-1:0] wdata,
	input  wire logic                   done,
	input  wire logic [`DMA_DATA_W-1:0] eng_rdata
);

	dma_ctrl_pkg::arb_state_t state;

	// core won the current or most recent transfer
	logic owner_core;
	logic any_req;
	logic pick_core;

	assign any_req   = dbg_fwd_val || core_fwd_val;
	// on a tie the gate not served last wins
	assign pick_core = core_fwd_val && (!dbg_fwd_val || !owner_core);

	// ----------------------------------------------------------------------
	// control
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			state         <= dma_ctrl_pkg::ARB_IDLE;
			owner_core    <= 1'b0;
			start         <= 1'b0;
			dbg_fwd_done  <= 1'b0;
			core_fwd_done <= 1'b0;
		end else begin
			start         <= 1'b0;
			dbg_fwd_done  <= 1'b0;
			core_fwd_done <= 1'b0;
			case (state)
				dma_ctrl_pkg::ARB_IDLE:
					if (any_req) begin
						state      <= dma_ctrl_pkg::ARB_BUSY;
						owner_core <= pick_core;
						start      <= 1'b1;
					end
				dma_ctrl_pkg::ARB_BUSY: begin
					// done goes back one cycle after the engine
					if (done) begin
						dbg_fwd_done  <= !owner_core;
						core_fwd_done <= owner_core;
					end
					// gate drops fwd_val after its done pulse
					if (dbg_fwd_done || core_fwd_done) begin
						state <= dma_ctrl_pkg::ARB_IDLE;
					end
				end
				default:
					state <= dma_ctrl_pkg::ARB_IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------------------
	// command and result registers
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (state == dma_ctrl_pkg::ARB_IDLE && any_req) begin
			if (pick_core) begin
				op    <= core_fwd_payload.op;
				src   <= core_fwd_payload.src;
				dest  <= core_fwd_payload.dest;
				wdata <= core_fwd_payload.wdata;
			end else begin
				// debug carries no write data
				op    <= dbg_fwd_payload.op;
				src   <= dbg_fwd_payload.src;
				dest  <= dbg_fwd_payload.dest;
				wdata <= '0;
			end
		end
		if (done) begin
			fwd_rdata <= eng_rdata;
		end
	end

endmodule

`default_nettype wire

//--- dma_ctrl_pkg.sv
// dma control state types

`default_nettype none

package dma_ctrl_pkg;

	// domain gate fsm
	typedef enum logic [2:0] {
		GATE_IDLE  = 3'd0,
		GATE_CHECK = 3'd1,
		GATE_FWD   = 3'd2,
		GATE_WAIT  = 3'd3,
		GATE_RESP  = 3'd4
	} gate_state_t;

	// arbiter fsm
	// busy covers the engine run and the done pulse back to the gate
	typedef enum logic {
		ARB_IDLE = 1'b0,
		ARB_BUSY = 1'b1
	} arb_state_t;

endpackage

`default_nettype wire

//--- dma_engine.sv
// word memory dma engine

`timescale 1ns/1ns
`default_nettype none

`include "dma_sec_consts.svh"

module dma_engine (
	input  wire logic                   clk,
	input  wire logic                   reset,

	// command from the arbiter
	input  wire logic                   start,
	input  wire dma_req_pkg::op_t       op,
	input  wire logic [`DMA_ADDR_W-1:0] src,
	input  wire logic [`DMA_ADDR_W-1:0] dest,
	input  wire logic [`DMA_DATA_W-1:0] wdata,

	// completion
	output logic                        done,
	output logic      [`DMA_DATA_W-1:0] rdata
);

	// ----------------------------------------------------------------------
	// storage
	// ----------------------------------------------------------------------

	logic [`DMA_DATA_W-1:0] mem [`DMA_MEM_WORDS];

	// second step of copy pending
	logic                   copy_step;
	// copy target, held for the second step
	logic [`DMA_ADDR_W-1:0] copy_dest;

	// ----------------------------------------------------------------------
	// sequencer
	// ----------------------------------------------------------------------

	// read and write finish in one cycle, copy in two
	always_ff @(posedge clk) begin
		if (reset) begin
			done      <= 1'b0;
			copy_step <= 1'b0;
		end else begin
			done      <= (start && op != dma_req_pkg::OP_COPY) || copy_step;
			copy_step <= start && op == dma_req_pkg::OP_COPY;
		end
	end

	// ----------------------------------------------------------------------
	// datapath
	// ----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		// copy writes back the word read in the first step
		if (copy_step) begin
			mem[copy_dest] <= rdata;
		end else if (start && op == dma_req_pkg::OP_WRITE) begin
			mem[dest] <= wdata;
		end

		if (start) begin
			copy_dest <= dest;
			// write echoes its own data
			if (op == dma_req_pkg::OP_WRITE) begin
				rdata <= wdata;
			end else begin
				rdata <= mem[src];
			end
		end
	end

endmodule

`default_nettype wire

//--- dma_req_pkg.sv
// dma request payload types

`default_nettype none

`include "dma_sec_consts.svh"

package dma_req_pkg;

	// engine operation code
	typedef enum logic [1:0] {
		OP_READ  = 2'd0,
		OP_COPY  = 2'd1,
		OP_WRITE = 2'd2
	} op_t;

	// debug port, read and copy only, no write data
	typedef struct packed {
		op_t                   op;
		logic [`DMA_ADDR_W-1:0] src;
		logic [`DMA_ADDR_W-1:0] dest;
	} dbg_req_t;

	// core port, full command plus tag
	typedef struct packed {
		op_t                   op;
		logic [`DMA_ADDR_W-1:0] src;
		logic [`DMA_ADDR_W-1:0] dest;
		logic [`DMA_DATA_W-1:0] wdata;
		logic [`DMA_TAG_W-1:0]  tag;
	} core_req_t;

endpackage

`default_nettype wire

//--- dma_sec_consts.svh
// secure dma width constants

`ifndef DMA_SEC_CONSTS_SVH
`define DMA_SEC_CONSTS_SVH

// ----------------------------------------------------------------------
// datapath widths
// ----------------------------------------------------------------------

// word address into the shared memory
`define DMA_ADDR_W 8
// memory word
`define DMA_DATA_W 16
// requester security domain and dma level
`define DMA_DOM_W 2
// core request tag, returned with the response
`define DMA_TAG_W 4

// one word per address
`define DMA_MEM_WORDS 256

`endif

//--- domain_gate.sv
// security domain gate

`timescale 1ns/1ns
`default_nettype none

`include "dma_sec_consts.svh"

module domain_gate #(
	parameter type payload_t = logic
) (
	input  wire logic                   clk,
	input  wire logic                   reset,

	// requester side
	input  wire logic                   val,
	input  wire logic [`DMA_DOM_W-1:0]  domain,
	input  wire payload_t               payload,
	output logic                        ack,
	output logic                        denied,
	output logic      [`DMA_DATA_W-1:0] rdata,
	output payload_t                    resp_payload,

	// configured level of the dma
	input  wire logic [`DMA_DOM_W-1:0]  dma_level,

	// arbiter side
	output logic                        fwd_val,
	output payload_t                    fwd_payload,
	input  wire logic                   fwd_done,
	input  wire logic [`DMA_DATA_W-1:0] fwd_rdata
);

	// ----------------------------------------------------------------------
	// state
	// ----------------------------------------------------------------------

	dma_ctrl_pkg::gate_state_t state;
	dma_ctrl_pkg::gate_state_t state_next;

	// captured request
	logic [`DMA_DOM_W-1:0]  domain_reg;
	payload_t               payload_reg;

	// response
	logic                   denied_reg;
	logic [`DMA_DATA_W-1:0] rdata_reg;

	// domain at or above the dma level
	logic                   grant;

	assign grant = (domain_reg >= dma_level);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dma_ctrl_pkg::GATE_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// ----------------------------------------------------------------------
	// next state
	// ----------------------------------------------------------------------

	always_comb begin
		state_next = state;
		case (state)
			dma_ctrl_pkg::GATE_IDLE:
				if (val) begin
					state_next = dma_ctrl_pkg::GATE_CHECK;
				end
			// denied requests skip the arbiter entirely
			dma_ctrl_pkg::GATE_CHECK:
				state_next = grant ? dma_ctrl_pkg::GATE_FWD : dma_ctrl_pkg::GATE_RESP;
			dma_ctrl_pkg::GATE_FWD:
				state_next = fwd_done ? dma_ctrl_pkg::GATE_RESP : dma_ctrl_pkg::GATE_WAIT;
			// held here under back-pressure
			dma_ctrl_pkg::GATE_WAIT:
				if (fwd_done) begin
					state_next = dma_ctrl_pkg::GATE_RESP;
				end
			dma_ctrl_pkg::GATE_RESP:
				state_next = dma_ctrl_pkg::GATE_IDLE;
			default:
				state_next = dma_ctrl_pkg::GATE_IDLE;
		endcase
	end

	// ----------------------------------------------------------------------
	// request capture and result
	// ----------------------------------------------------------------------

	// denied flag, decided once per request in check
	always_ff @(posedge clk) begin
		if (reset) begin
			denied_reg <= 1'b0;
		end else if (state == dma_ctrl_pkg::GATE_CHECK) begin
			denied_reg <= !grant;
		end
	end

	always_ff @(posedge clk) begin
		// only accepted while idle
		if (state == dma_ctrl_pkg::GATE_IDLE && val) begin
			domain_reg  <= domain;
			payload_reg <= payload;
		end
		// zero data on deny, engine result on grant
		if (state == dma_ctrl_pkg::GATE_CHECK && !grant) begin
			rdata_reg <= '0;
		end else if ((state == dma_ctrl_pkg::GATE_FWD || state == dma_ctrl_pkg::GATE_WAIT)
				&& fwd_done) begin
			rdata_reg <= fwd_rdata;
		end
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------

	assign fwd_val      = (state == dma_ctrl_pkg::GATE_FWD) || (state == dma_ctrl_pkg::GATE_WAIT);
	assign fwd_payload  = payload_reg;

	// one-cycle response
	assign ack          = (state == dma_ctrl_pkg::GATE_RESP);
	assign denied       = ack && denied_reg;
	assign rdata        = rdata_reg;
	assign resp_payload = payload_reg;

endmodule

`default_nettype wire

//--- filelist.f
+incdir+.
dma_req_pkg.sv
dma_ctrl_pkg.sv
domain_gate.sv
dma_arbiter.sv
dma_engine.sv
secure_dma_top.sv
secure_dma_chk.sv
secure_dma_tb.sv

//--- secure_dma_chk.sv
// secure dma protocol checks

`timescale 1ns/1ns
`default_nettype none

`include "dma_sec_consts.svh"

module secure_dma_chk (
	input  wire logic                   clk,
	input  wire logic                   reset,
	// requester strobes and responses
	input  wire logic                   dbg_val,
	input  wire logic                   dbg_ack,
	input  wire logic                   dbg_denied,
	input  wire logic [`DMA_DATA_W-1:0] dbg_rdata,
	input  wire logic                   core_val,
	input  wire logic                   core_ack,
	input  wire logic                   core_denied,
	input  wire logic [`DMA_DATA_W-1:0] core_rdata,
	// internal handshakes
	input  wire logic                   dbg_fwd_val,
	input  wire logic                   core_fwd_val,
	input  wire logic                   dbg_fwd_done,
	input  wire logic                   core_fwd_done,
	input  wire logic                   start,
	input  wire logic                   done
);

	// failed assertions so far
	int unsigned err_count = 0;

	// request open on each port
	logic dbg_open;
	logic core_open;
	// engine between start and done
	logic eng_busy;

	always_ff @(posedge clk) begin
		if (reset) begin
			dbg_open  <= 1'b0;
			core_open <= 1'b0;
			eng_busy  <= 1'b0;
		end else begin
			if (dbg_ack) begin
				dbg_open <= 1'b0;
			end else if (dbg_val) begin
				dbg_open <= 1'b1;
			end
			if (core_ack) begin
				core_open <= 1'b0;
			end else if (core_val) begin
				core_open <= 1'b1;
			end
			if (start) begin
				eng_busy <= 1'b1;
			end else if (done) begin
				eng_busy <= 1'b0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// properties
	// ----------------------------------------------------------------------

	dbg_ack_has_req: assert property (@(posedge clk) disable iff (reset)
		dbg_ack |-> dbg_open)
		else begin
			$error("debug ack with no accepted debug request");
			err_count++;
		end

	core_ack_has_req: assert property (@(posedge clk) disable iff (reset)
		core_ack |-> core_open)
		else begin
			$error("core ack with no accepted core request");
			err_count++;
		end

	// denied responses carry no data
	denied_zero_data: assert property (@(posedge clk) disable iff (reset)
		(dbg_ack && dbg_denied |-> dbg_rdata == '0)
		and (core_ack && core_denied |-> core_rdata == '0))
		else begin
			$error("denied ack carries nonzero data");
			err_count++;
		end

	start_when_idle: assert property (@(posedge clk) disable iff (reset)
		start |-> !eng_busy)
		else begin
			$error("start issued while the engine is busy");
			err_count++;
		end

	strobes_low_after_reset: assert property (@(posedge clk)
		reset |=> !(dbg_ack || core_ack || dbg_denied || core_denied || dbg_fwd_val
		|| core_fwd_val || dbg_fwd_done || core_fwd_done || start || done))
		else begin
			$error("strobe high in the cycle after reset");
			err_count++;
		end

endmodule

bind secure_dma_top secure_dma_chk chk (
	.clk(clk), .reset(reset),
	.dbg_val(dbg_val), .dbg_ack(dbg_ack), .dbg_denied(dbg_denied), .dbg_rdata(dbg_rdata),
	.core_val(core_val), .core_ack(core_ack), .core_denied(core_denied),
	.core_rdata(core_rdata),
	.dbg_fwd_val(dbg_fwd_val), .core_fwd_val(core_fwd_val),
	.dbg_fwd_done(dbg_fwd_done), .core_fwd_done(core_fwd_done),
	.start(start), .done(done)
);

`default_nettype wire

//--- secure_dma_tb.sv
// secure dma testbench

`timescale 1ns/1ns
`default_nettype none

`include "dma_sec_consts.svh"

module secure_dma_tb;

	// total request count for the watchdog
	localparam int NUM_OPS = 150;
	// all traffic stays inside the preloaded address window
	localparam int WIN = 16;
	localparam logic [`DMA_ADDR_W-1:0] BASE = 8'h40;

	logic                   clk;
	logic                   reset;
	logic [`DMA_DOM_W-1:0]  dma_level;
	logic                   dbg_val;
	logic [`DMA_DOM_W-1:0]  dbg_domain;
	dma_req_pkg::op_t       dbg_op;
	logic [`DMA_ADDR_W-1:0] dbg_src;
	logic [`DMA_ADDR_W-1:0] dbg_dest;
	logic                   dbg_ack;
	logic                   dbg_denied;
	logic [`DMA_DATA_W-1:0] dbg_rdata;
	logic                   core_val;
	logic [`DMA_DOM_W-1:0]  core_domain;
	dma_req_pkg::op_t       core_op;
	logic [`DMA_ADDR_W-1:0] core_src;
	logic [`DMA_ADDR_W-1:0] core_dest;
	logic [`DMA_DATA_W-1:0] core_wdata;
	logic [`DMA_TAG_W-1:0]  core_tag;
	logic                   core_ack;
	logic                   core_denied;
	logic [`DMA_DATA_W-1:0] core_rdata;
	logic [`DMA_TAG_W-1:0]  core_rtag;

	// reference memory updated on granted acks only
	logic [`DMA_DATA_W-1:0] ref_mem [`DMA_MEM_WORDS];

	secure_dma_top dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string what, input logic [`DMA_DATA_W-1:0] actual,
			input logic [`DMA_DATA_W-1:0] expected);
		assert (actual === expected)
		else fail_run($sformatf("MISMATCH at %0t ns: %s is %h, expected %h", $time, what,
			actual, expected));
	endtask

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------

	// ack order follows engine order so the model runs at the ack
	task automatic model_op(input dma_req_pkg::op_t op, input logic [7:0] src,
			input logic [7:0] dest, input logic [15:0] wdata, input logic [1:0] domain,
			output logic exp_denied, output logic [15:0] exp_data);
		exp_denied = (domain < dma_level);
		exp_data   = '0;
		if (!exp_denied) begin
			case (op)
				dma_req_pkg::OP_WRITE: begin
					exp_data      = wdata;
					ref_mem[dest] = wdata;
				end
				dma_req_pkg::OP_COPY: begin
					exp_data      = ref_mem[src];
					ref_mem[dest] = ref_mem[src];
				end
				default: exp_data = ref_mem[src];
			endcase
		end
	endtask

	function automatic logic [`DMA_ADDR_W-1:0] rand_addr();
		return BASE + 8'($urandom_range(WIN - 1));
	endfunction

	// ----------------------------------------------------------------------
	// requesters
	// ----------------------------------------------------------------------

	task automatic dbg_request(input dma_req_pkg::op_t op, input logic [7:0] src,
			input logic [7:0] dest, input logic [1:0] domain);
		logic        exp_denied;
		logic [15:0] exp_data;
		@(negedge clk);
		dbg_val    = 1'b1;
		dbg_op     = op;
		dbg_src    = src;
		dbg_dest   = dest;
		dbg_domain = domain;
		@(negedge clk);
		dbg_val    = 1'b0;
		// gate works from its captured copy from here on
		dbg_src    = ~src;
		dbg_dest   = ~dest;
		dbg_domain = ~domain;
		while (!dbg_ack) begin
			@(negedge clk);
		end
		model_op(op, src, dest, '0, domain, exp_denied, exp_data);
		check_word("debug denied", 16'(dbg_denied), 16'(exp_denied));
		check_word("debug rdata", dbg_rdata, exp_data);
	endtask

	task automatic core_request(input dma_req_pkg::op_t op, input logic [7:0] src,
			input logic [7:0] dest, input logic [15:0] wdata, input logic [1:0] domain);
		logic        exp_denied;
		logic [15:0] exp_data;
		logic [3:0]  tag;
		tag = 4'($urandom_range(15));
		@(negedge clk);
		core_val    = 1'b1;
		core_op     = op;
		core_src    = src;
		core_dest   = dest;
		core_wdata  = wdata;
		core_tag    = tag;
		core_domain = domain;
		@(negedge clk);
		core_val    = 1'b0;
		// gate works from its captured copy from here on
		core_src    = ~src;
		core_dest   = ~dest;
		core_wdata  = ~wdata;
		core_tag    = ~tag;
		core_domain = ~domain;
		while (!core_ack) begin
			@(negedge clk);
		end
		model_op(op, src, dest, wdata, domain, exp_denied, exp_data);
		check_word("core denied", 16'(core_denied), 16'(exp_denied));
		check_word("core rdata", core_rdata, exp_data);
		// tag in flight comes back unchanged
		check_word("core rtag", 16'(core_rtag), 16'(tag));
	endtask

	task automatic dbg_traffic(input int count);
		repeat (count) begin
			repeat ($urandom_range(3)) @(negedge clk);
			dbg_request($urandom_range(1) ? dma_req_pkg::OP_COPY : dma_req_pkg::OP_READ,
				rand_addr(), rand_addr(), 2'($urandom_range(3)));
		end
	endtask

	task automatic core_traffic(input int count);
		repeat (count) begin
			repeat ($urandom_range(3)) @(negedge clk);
			core_request(dma_req_pkg::op_t'(2'($urandom_range(2))), rand_addr(), rand_addr(),
				16'($urandom), 2'($urandom_range(3)));
		end
	endtask

	// ----------------------------------------------------------------------
	// sequence
	// ----------------------------------------------------------------------

	initial begin
		void'($urandom(32'hc3a4075f));
		reset       = 1'b1;
		dma_level   = 2'd0;
		dbg_val     = 1'b0;
		dbg_domain  = 2'd0;
		dbg_op      = dma_req_pkg::OP_READ;
		dbg_src     = '0;
		dbg_dest    = '0;
		core_val    = 1'b0;
		core_domain = 2'd0;
		core_op     = dma_req_pkg::OP_READ;
		core_src    = '0;
		core_dest   = '0;
		core_wdata  = '0;
		core_tag    = '0;
		repeat (10) @(negedge clk);
		reset = 1'b0;

		// quiet bus until the first request
		repeat (5) begin
			@(negedge clk);
			assert (!dbg_ack && !core_ack && !dut.start)
			else fail_run("an ack or start appeared before any request was driven");
		end

		// fill the window with a pattern from the whole address
		for (int i = 0; i < WIN; i++) begin
			core_request(dma_req_pkg::OP_WRITE, '0, BASE + 8'(i),
				{BASE + 8'(i), ~(BASE + 8'(i))}, 2'($urandom_range(3)));
		end

		// core write then debug read back
		core_request(dma_req_pkg::OP_WRITE, '0, BASE + 8'd5, 16'($urandom), 2'd3);
		dbg_request(dma_req_pkg::OP_READ, BASE + 8'd5, '0, 2'd0);

		// copy from each port and read the target from the other one
		dbg_request(dma_req_pkg::OP_COPY, BASE + 8'd1, BASE + 8'd2, 2'd1);
		core_request(dma_req_pkg::OP_READ, BASE + 8'd2, '0, '0, 2'd2);
		core_request(dma_req_pkg::OP_COPY, BASE + 8'd3, BASE + 8'd4, '0, 2'd0);
		dbg_request(dma_req_pkg::OP_READ, BASE + 8'd4, '0, 2'd3);

		// low domains are refused and leave memory alone
		dma_level = 2'd2;
		core_request(dma_req_pkg::OP_WRITE, '0, BASE + 8'd6, 16'($urandom), 2'd1);
		dbg_request(dma_req_pkg::OP_COPY, BASE + 8'd7, BASE + 8'd8, 2'd0);
		core_request(dma_req_pkg::OP_READ, BASE + 8'd6, '0, '0, 2'd3);
		dbg_request(dma_req_pkg::OP_READ, BASE + 8'd8, '0, 2'd2);

		// both ports in the same cycle
		dma_level = 2'd1;
		fork
			dbg_request(dma_req_pkg::OP_READ, BASE + 8'd9, '0, 2'd1);
			core_request(dma_req_pkg::OP_WRITE, '0, BASE + 8'd9, 16'($urandom), 2'd2);
		join
		fork
			dbg_request(dma_req_pkg::OP_COPY, BASE + 8'd10, BASE + 8'd11, 2'd3);
			core_request(dma_req_pkg::OP_READ, BASE + 8'd11, '0, '0, 2'd1);
		join

		// random rounds with the level changed while both ports are idle
		repeat (20) begin
			@(negedge clk);
			dma_level = 2'($urandom_range(3));
			fork
				dbg_traffic(3);
				core_traffic(3);
			join
		end

		repeat (4) @(negedge clk);
		if (dut.chk.err_count != 0) begin
			fail_run("a protocol assertion in the bound checker failed");
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

	// poll the bound checker every cycle
	always @(negedge clk) begin
		if (dut.chk.err_count != 0) begin
			fail_run("a protocol assertion in the bound checker failed");
		end
	end

	initial begin
		repeat (10 + NUM_OPS * 40) @(posedge clk);
		fail_run("timeout, the DUT stopped acknowledging requests");
	end

endmodule

`default_nettype wire

//--- secure_dma_top.sv
// secure dma front end top

`timescale 1ns/1ns
`default_nettype none

`include "dma_sec_consts.svh"

module secure_dma_top (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic [`DMA_DOM_W-1:0]  dma_level,

	// debug port
	input  wire logic                   dbg_val,
	input  wire logic [`DMA_DOM_W-1:0]  dbg_domain,
	input  wire dma_req_pkg::op_t       dbg_op,
	input  wire logic [`DMA_ADDR_W-1:0] dbg_src,
	input  wire logic [`DMA_ADDR_W-1:0] dbg_dest,
	output logic                        dbg_ack,
	output logic                        dbg_denied,
	output logic      [`DMA_DATA_W-1:0] dbg_rdata,

	// core port
	input  wire logic                   core_val,
	input  wire logic [`DMA_DOM_W-1:0]  core_domain,
	input  wire dma_req_pkg::op_t       core_op,
	input  wire logic [`DMA_ADDR_W-1:0] core_src,
	input  wire logic [`DMA_ADDR_W-1:0] core_dest,
	input  wire logic [`DMA_DATA_W-1:0] core_wdata,
	input  wire logic [`DMA_TAG_W-1:0]  core_tag,
	output logic                        core_ack,
	output logic                        core_denied,
	output logic      [`DMA_DATA_W-1:0] core_rdata,
	output logic      [`DMA_TAG_W-1:0]  core_rtag
);

	// ----------------------------------------------------------------------
	// request packing
	// ----------------------------------------------------------------------

	dma_req_pkg::dbg_req_t  dbg_req;
	dma_req_pkg::core_req_t core_req;
	dma_req_pkg::core_req_t core_resp;

	assign dbg_req  = '{op: dbg_op, src: dbg_src, dest: dbg_dest};
	assign core_req = '{op: core_op, src: core_src, dest: core_dest,
		wdata: core_wdata, tag: core_tag};

	// tag comes back from the captured core request
	assign core_rtag = core_resp.tag;

	// gate to arbiter
	logic                   dbg_fwd_val;
	logic                   dbg_fwd_done;
	dma_req_pkg::dbg_req_t  dbg_fwd_payload;
	logic                   core_fwd_val;
	logic                   core_fwd_done;
	dma_req_pkg::core_req_t core_fwd_payload;
	logic [`DMA_DATA_W-1:0] fwd_rdata;

	// arbiter to engine
	logic                   start;
	logic                   done;
	dma_req_pkg::op_t       eng_op;
	logic [`DMA_ADDR_W-1:0] eng_src;
	logic [`DMA_ADDR_W-1:0] eng_dest;
	logic [`DMA_DATA_W-1:0] eng_wdata;
	logic [`DMA_DATA_W-1:0] eng_rdata;

	// ----------------------------------------------------------------------
	// instances
	// ----------------------------------------------------------------------

	domain_gate #(.payload_t(dma_req_pkg::dbg_req_t)) dbg_gate (
		.clk(clk), .reset(reset),
		.val(dbg_val), .domain(dbg_domain), .payload(dbg_req),
		.ack(dbg_ack), .denied(dbg_denied), .rdata(dbg_rdata), .resp_payload(),
		.dma_level(dma_level),
		.fwd_val(dbg_fwd_val), .fwd_payload(dbg_fwd_payload),
		.fwd_done(dbg_fwd_done), .fwd_rdata(fwd_rdata)
	);

	domain_gate #(.payload_t(dma_req_pkg::core_req_t)) core_gate (
		.clk(clk), .reset(reset),
		.val(core_val), .domain(core_domain), .payload(core_req),
		.ack(core_ack), .denied(core_denied), .rdata(core_rdata), .resp_payload(core_resp),
		.dma_level(dma_level),
		.fwd_val(core_fwd_val), .fwd_payload(core_fwd_payload),
		.fwd_done(core_fwd_done), .fwd_rdata(fwd_rdata)
	);

	dma_arbiter arbiter (
		.clk(clk), .reset(reset),
		.dbg_fwd_val(dbg_fwd_val), .dbg_fwd_payload(dbg_fwd_payload),
		.dbg_fwd_done(dbg_fwd_done),
		.core_fwd_val(core_fwd_val), .core_fwd_payload(core_fwd_payload),
		.core_fwd_done(core_fwd_done),
		.fwd_rdata(fwd_rdata),
		.start(start), .op(eng_op), .src(eng_src), .dest(eng_dest), .wdata(eng_wdata),
		.done(done), .eng_rdata(eng_rdata)
	);

	dma_engine engine (
		.clk(clk), .reset(reset),
		.start(start), .op(eng_op), .src(eng_src), .dest(eng_dest), .wdata(eng_wdata),
		.done(done), .rdata(eng_rdata)
	);

endmodule

`default_nettype wire
